/* pipe_params.svh */
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// stall/flush vector width
// PC, IF/ID, ID/EX, EX/MEM, MEM/WB plus one reserved bit
`define PIPE_STAGES 6

// first fetch address after reset
`define PIPE_RESET_PC 32'h0000_0000

// ecall redirect target
`define PIPE_TRAP_VEC 32'h0000_0100

`define PIPE_MUL_CYCLES 8  // shift-add iterations, one per operand bit

// APB address width, data is one byte
`define PIPE_APB_AW 16

`endif

/* pipe_pkg.sv */
`include "pipe_params.svh"

package pipe_pkg;

  // zero encoding doubles as the bubble
  typedef enum logic [2:0] {
    KIND_NOP   = 3'd0,
    KIND_ALU   = 3'd1,
    KIND_LOAD  = 3'd2,
    KIND_STORE = 3'd3,
    KIND_JUMP  = 3'd4,
    KIND_MUL   = 3'd5,
    KIND_ECALL = 3'd6
  } instr_kind_e;

  // same layout as the imem word, kind in the top bits
  typedef struct packed {
    instr_kind_e kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [7:0]  op_a;
    logic [7:0]  op_b;
    logic [2:0]  pad;
  } instr_t;

  typedef struct packed {
    logic [31:0] pc;
    instr_t      instr;
  } if_id_t;

  typedef struct packed {
    logic [31:0] pc;
    instr_t      instr;
  } id_ex_t;

  typedef struct packed {
    logic [31:0] pc;
    instr_kind_e kind;
    logic [4:0]  rd;
    logic [15:0] result;  // address for load/store
  } ex_mem_t;

  typedef struct packed {
    logic [31:0] pc;
    instr_kind_e kind;
    logic [4:0]  rd;
    logic [15:0] data;
  } mem_wb_t;

  typedef logic [`PIPE_STAGES-1:0] stage_vec_t;

endpackage

/* pipe_ctrl_if.sv */
`timescale 1ns/1ns

interface pipe_ctrl_if import pipe_pkg::*; ();

  logic if_stall_req;   // imem request waiting for grant
  logic mul_busy;       // multiplier still iterating
  logic jump_taken;     // jump sitting in EX
  logic mem_stall_req;  // APB transfer not finished
  logic trap_req;       // ecall in WB

  stage_vec_t stall;
  stage_vec_t flush;

  modport ctrl (
    input  if_stall_req, mul_busy, jump_taken, mem_stall_req, trap_req,
    output stall, flush
  );

  // fetch needs to know about redirects and EX holds
  modport fetch (
    output if_stall_req,
    input  stall, jump_taken, mul_busy, trap_req
  );

  modport exec (
    output mul_busy, jump_taken,
    input  stall
  );

  modport mem (
    output mem_stall_req
  );

  modport retire (
    output trap_req,
    input  stall
  );

endinterface

/* pipe_ctrl.sv */
`timescale 1ns/1ns

module pipe_ctrl import pipe_pkg::*; (
  input logic         rst,
  pipe_ctrl_if.ctrl   ctrl,
  input if_id_t       if_id_i,
  input id_ex_t       id_ex_i
);

  // bit order: PC, IF/ID, ID/EX, EX/MEM, MEM/WB, reserved
  localparam stage_vec_t MEM_STALL  = 6'b001111;
  localparam stage_vec_t MEM_FLUSH  = 6'b010000;
  localparam stage_vec_t IF_STALL   = 6'b000011;
  localparam stage_vec_t IF_FLUSH   = 6'b000000;
  localparam stage_vec_t TRAP_STALL = 6'b000010;
  localparam stage_vec_t TRAP_FLUSH = 6'b001110;
  localparam stage_vec_t JUMP_STALL = 6'b000010;
  localparam stage_vec_t JUMP_FLUSH = 6'b000110;
  localparam stage_vec_t MUL_STALL  = 6'b000111;
  localparam stage_vec_t MUL_FLUSH  = 6'b001000;
  localparam stage_vec_t LU_STALL   = 6'b000011;
  localparam stage_vec_t LU_FLUSH   = 6'b000100;
  localparam stage_vec_t RST_FLUSH  = 6'b011111;

  logic       load_use;
  stage_vec_t stall_v;
  stage_vec_t flush_v;

  // load in EX whose rd feeds the instruction in ID
  assign load_use = (id_ex_i.instr.kind == KIND_LOAD) &&
                    (id_ex_i.instr.rd != 5'd0) &&
                    (id_ex_i.instr.rd == if_id_i.instr.rs1);

  // later stages win
  always_comb begin
    if (rst) begin
      stall_v = '0;
      flush_v = RST_FLUSH;
    end else if (ctrl.mem_stall_req) begin
      stall_v = MEM_STALL;
      flush_v = MEM_FLUSH;
    end else if (ctrl.if_stall_req) begin
      stall_v = IF_STALL;
      flush_v = IF_FLUSH;
    end else if (ctrl.trap_req) begin
      stall_v = TRAP_STALL;  // PC free to take the trap vector
      flush_v = TRAP_FLUSH;
    end else if (ctrl.jump_taken) begin
      stall_v = JUMP_STALL;
      flush_v = JUMP_FLUSH;
    end else if (ctrl.mul_busy) begin
      stall_v = MUL_STALL;
      flush_v = MUL_FLUSH;
    end else if (load_use) begin
      // one bubble into EX
      stall_v = LU_STALL;
      flush_v = LU_FLUSH;
    end else begin
      stall_v = '0;
      flush_v = '0;
    end
  end

  assign ctrl.stall = stall_v;
  assign ctrl.flush = flush_v;

endmodule

/* stage_reg.sv */
`timescale 1ns/1ns

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall_i,
  input  logic     flush_i,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t q;

  // flush beats stall, all-zero payload is a NOP
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      q <= '0;
    end else if (!stall_i) begin
      q <= d_i;
    end
  end

  assign q_o = q;

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ns
`include "pipe_params.svh"

module fetch_unit import pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  pipe_ctrl_if.fetch  ctl,
  input  logic [31:0] redirect_pc_i,
  output logic        imem_req_o,
  output logic [31:0] imem_addr_o,
  input  logic        imem_gnt_i,
  input  logic [31:0] imem_rdata_i,
  output if_id_t      if_id_o
);

  logic [31:0] pc_q;
  logic        req_q;
  logic        fetched;

  assign fetched = req_q && imem_gnt_i;

  // a pending redirect or EX hold already freezes the front end
  assign ctl.if_stall_req = req_q && !imem_gnt_i && !ctl.jump_taken &&
                            !ctl.trap_req && !ctl.mul_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q  <= `PIPE_RESET_PC;
      req_q <= 1'b0;
    end else begin
      req_q <= 1'b1;
      if (!ctl.stall[0]) begin
        if (ctl.trap_req) begin
          pc_q <= `PIPE_TRAP_VEC;
        end else if (ctl.jump_taken) begin
          pc_q <= redirect_pc_i;
        end else if (fetched) begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

  assign imem_req_o  = req_q;
  assign imem_addr_o = pc_q;

  always_comb begin
    if (fetched) begin
      if_id_o = '{pc: pc_q, instr: instr_t'(imem_rdata_i)};
    end else begin
      if_id_o = '0;  // no grant, bubble
    end
  end

endmodule

/* exec_unit.sv */
`timescale 1ns/1ns
`include "pipe_params.svh"

module exec_unit import pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  pipe_ctrl_if.exec   ctl,
  input  id_ex_t      id_ex_i,
  output ex_mem_t     ex_mem_o,
  output logic [31:0] redirect_pc_o
);

  logic [15:0] sum;
  logic [31:0] link;
  logic [3:0]  mul_cnt;
  logic [15:0] mul_acc;
  logic        mul_done_q;

  assign sum  = {8'h00, id_ex_i.instr.op_a} + {8'h00, id_ex_i.instr.op_b};
  assign link = id_ex_i.pc + 32'd4;

  assign ctl.jump_taken = (id_ex_i.instr.kind == KIND_JUMP);
  assign ctl.mul_busy   = (id_ex_i.instr.kind == KIND_MUL) && !mul_done_q;
  assign redirect_pc_o  = {22'd0, id_ex_i.instr.op_a, 2'b00};

  // shift-add, one multiplier bit per cycle
  // state clears whenever EX hands its instruction on
  always_ff @(posedge clk) begin
    if (rst || !ctl.stall[2]) begin
      mul_cnt    <= '0;
      mul_acc    <= '0;
      mul_done_q <= 1'b0;
    end else if (ctl.mul_busy) begin
      if (id_ex_i.instr.op_b[mul_cnt[2:0]]) begin
        mul_acc <= mul_acc + ({8'h00, id_ex_i.instr.op_a} << mul_cnt);
      end
      mul_cnt <= mul_cnt + 4'd1;
      if (mul_cnt == 4'(`PIPE_MUL_CYCLES - 1)) begin
        mul_done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    ex_mem_o.pc   = id_ex_i.pc;
    ex_mem_o.kind = id_ex_i.instr.kind;
    ex_mem_o.rd   = id_ex_i.instr.rd;
    case (id_ex_i.instr.kind)
      KIND_ALU:   ex_mem_o.result = sum;
      KIND_LOAD:  ex_mem_o.result = {8'h00, sum[7:0]};
      KIND_STORE: ex_mem_o.result = {id_ex_i.instr.op_b, sum[7:0]};  // data rides on top
      KIND_JUMP:  ex_mem_o.result = link[15:0];
      KIND_MUL:   ex_mem_o.result = mul_acc;
      default:    ex_mem_o.result = '0;
    endcase
  end

endmodule

/* mem_apb.sv */
`timescale 1ns/1ns
`include "pipe_params.svh"

module mem_apb import pipe_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  pipe_ctrl_if.mem                ctl,
  input  ex_mem_t                 ex_mem_i,
  output mem_wb_t                 mem_wb_o,
  output logic                    psel_o,
  output logic                    penable_o,
  output logic                    pwrite_o,
  output logic [`PIPE_APB_AW-1:0] paddr_o,
  output logic [7:0]              pwdata_o,
  input  logic [7:0]              prdata_i,
  input  logic                    pready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  apb_state_e state_q;
  logic       is_load;
  logic       is_store;
  logic       is_mem;
  logic       xfer_done;

  assign is_load   = (ex_mem_i.kind == KIND_LOAD);
  assign is_store  = (ex_mem_i.kind == KIND_STORE);
  assign is_mem    = is_load || is_store;
  assign xfer_done = (state_q == ST_ACCESS) && pready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:   if (is_mem) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: if (pready_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // EX/MEM stays put until the transfer ends, so the bus fields hold steady
  assign ctl.mem_stall_req = is_mem && !xfer_done;

  assign psel_o    = (state_q != ST_IDLE);
  assign penable_o = (state_q == ST_ACCESS);
  assign pwrite_o  = psel_o && is_store;
  assign paddr_o   = {{(`PIPE_APB_AW - 8){1'b0}}, ex_mem_i.result[7:0]};
  assign pwdata_o  = ex_mem_i.result[15:8];

  always_comb begin
    mem_wb_o.pc   = ex_mem_i.pc;
    mem_wb_o.kind = ex_mem_i.kind;
    mem_wb_o.rd   = ex_mem_i.rd;
    if (is_load) begin
      mem_wb_o.data = {8'h00, prdata_i};  // only sampled on the pready cycle
    end else begin
      mem_wb_o.data = ex_mem_i.result;
    end
  end

endmodule

/* retire_unit.sv */
`timescale 1ns/1ns

module retire_unit import pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  pipe_ctrl_if.retire ctl,
  input  mem_wb_t     mem_wb_i,
  output logic        retire_valid_o,
  output logic [31:0] retire_pc_o,
  output instr_kind_e retire_kind_o,
  output logic [4:0]  retire_rd_o,
  output logic [15:0] retire_data_o
);

  logic ecall_wb;
  logic trap_pend_q;  // trap held off by an APB wait
  logic kill_q;       // drop the instruction that was in MEM behind the ecall

  assign ecall_wb     = (mem_wb_i.kind == KIND_ECALL) && !kill_q;
  assign ctl.trap_req = ecall_wb || trap_pend_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      trap_pend_q    <= 1'b0;
      kill_q         <= 1'b0;
      retire_valid_o <= 1'b0;
    end else begin
      // PC stall means a higher priority hazard won this cycle
      trap_pend_q    <= ctl.trap_req && ctl.stall[0];
      kill_q         <= ctl.trap_req && !ctl.stall[0];
      retire_valid_o <= (mem_wb_i.kind != KIND_NOP) && !kill_q;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc_o   <= mem_wb_i.pc;
    retire_kind_o <= mem_wb_i.kind;
    retire_rd_o   <= mem_wb_i.rd;
    retire_data_o <= mem_wb_i.data;
  end

endmodule

/* pipe_top.sv */
`timescale 1ns/1ns
`include "pipe_params.svh"

module pipe_top import pipe_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    imem_req_o,
  output logic [31:0]             imem_addr_o,
  input  logic                    imem_gnt_i,
  input  logic [31:0]             imem_rdata_i,
  output logic                    psel_o,
  output logic                    penable_o,
  output logic                    pwrite_o,
  output logic [`PIPE_APB_AW-1:0] paddr_o,
  output logic [7:0]              pwdata_o,
  input  logic [7:0]              prdata_i,
  input  logic                    pready_i,
  output logic                    retire_valid_o,
  output logic [31:0]             retire_pc_o,
  output instr_kind_e             retire_kind_o,
  output logic [4:0]              retire_rd_o,
  output logic [15:0]             retire_data_o
);

  pipe_ctrl_if ctl_if ();

  if_id_t      if_id_d, if_id_q;
  id_ex_t      id_ex_q;
  ex_mem_t     ex_mem_d, ex_mem_q;
  mem_wb_t     mem_wb_d, mem_wb_q;
  logic [31:0] redirect_pc;
  logic        id_ex_bubble;

  // IF/ID held while ID/EX moves on, so EX must not see the same instruction twice
  assign id_ex_bubble = ctl_if.flush[2] | (ctl_if.stall[1] & ~ctl_if.stall[2]);

  pipe_ctrl u_ctrl (.rst(rst), .ctrl(ctl_if.ctrl), .if_id_i(if_id_q), .id_ex_i(id_ex_q));

  fetch_unit u_fetch (
    .clk(clk), .rst(rst), .ctl(ctl_if.fetch), .redirect_pc_i(redirect_pc),
    .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o), .imem_gnt_i(imem_gnt_i),
    .imem_rdata_i(imem_rdata_i), .if_id_o(if_id_d)
  );

  stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .rst(rst), .stall_i(ctl_if.stall[1]), .flush_i(ctl_if.flush[1]),
    .d_i(if_id_d), .q_o(if_id_q)
  );

  stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .rst(rst), .stall_i(ctl_if.stall[2]), .flush_i(id_ex_bubble),
    .d_i(id_ex_t'(if_id_q)), .q_o(id_ex_q)
  );

  exec_unit u_exec (
    .clk(clk), .rst(rst), .ctl(ctl_if.exec), .id_ex_i(id_ex_q),
    .ex_mem_o(ex_mem_d), .redirect_pc_o(redirect_pc)
  );

  stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk(clk), .rst(rst), .stall_i(ctl_if.stall[3]), .flush_i(ctl_if.flush[3]),
    .d_i(ex_mem_d), .q_o(ex_mem_q)
  );

  mem_apb u_mem (
    .clk(clk), .rst(rst), .ctl(ctl_if.mem), .ex_mem_i(ex_mem_q), .mem_wb_o(mem_wb_d),
    .psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o), .paddr_o(paddr_o),
    .pwdata_o(pwdata_o), .prdata_i(prdata_i), .pready_i(pready_i)
  );

  stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk(clk), .rst(rst), .stall_i(ctl_if.stall[4]), .flush_i(ctl_if.flush[4]),
    .d_i(mem_wb_d), .q_o(mem_wb_q)
  );

  retire_unit u_retire (
    .clk(clk), .rst(rst), .ctl(ctl_if.retire), .mem_wb_i(mem_wb_q),
    .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
    .retire_kind_o(retire_kind_o), .retire_rd_o(retire_rd_o),
    .retire_data_o(retire_data_o)
  );

endmodule

/* pipe_asserts.sv */
`timescale 1ns/1ns

module pipe_asserts import pipe_pkg::*; (
  input logic       clk,
  input logic       rst,
  input stage_vec_t stall_i,
  input stage_vec_t flush_i,
  input logic       mem_stall_i,
  input logic       psel_i,
  input logic       penable_i
);

  // every stage register cleared while reset is high
  a_rst_flush: assert property (@(posedge clk) rst |-> flush_i == 6'b011111)
    else $error("flush vector is %b during reset", flush_i);

  a_mem_stall_pc: assert property (@(posedge clk) disable iff (rst)
    mem_stall_i |-> stall_i[0])
    else $error("memory stage stalls but the PC is not held");

  a_penable_psel: assert property (@(posedge clk) disable iff (rst)
    penable_i |-> psel_i)
    else $error("penable high without psel");

endmodule

// controller vectors and APB handshake, sampled on the top-level clock
bind pipe_top pipe_asserts u_asserts (
  .clk(clk),
  .rst(rst),
  .stall_i(ctl_if.stall),
  .flush_i(ctl_if.flush),
  .mem_stall_i(ctl_if.mem_stall_req),
  .psel_i(psel_o),
  .penable_i(penable_o)
);

/* pipe_tb.sv */
`timescale 1ns/1ns
`include "pipe_params.svh"

module pipe_tb import pipe_pkg::*; ();

  logic                    clk;
  logic                    rst;
  logic                    imem_req;
  logic [31:0]             imem_addr;
  logic                    imem_gnt_i;
  logic [31:0]             imem_rdata_i;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`PIPE_APB_AW-1:0] paddr;
  logic [7:0]              pwdata;
  logic [7:0]              prdata_i;
  logic                    pready_i;
  logic                    retire_valid;
  logic [31:0]             retire_pc;
  instr_kind_e             retire_kind;
  logic [4:0]              retire_rd;
  logic [15:0]             retire_data;

  logic [31:0] prog [0:127];
  logic [7:0]  apb_mem [0:255];
  logic [7:0]  model_mem [0:255];  // reference walk's view of the slave

  logic [31:0] exp_pc[$];
  instr_kind_e exp_kind[$];
  logic [4:0]  exp_rd[$];
  logic [15:0] exp_data[$];
  logic [31:0] got_pc[$];
  instr_kind_e got_kind[$];
  logic [4:0]  got_rd[$];
  logic [15:0] got_data[$];

  integer      seed = 85549;
  logic [31:0] rnd;
  logic        gnt_random;
  logic        ready_random;
  int          errors;
  int          checks;

  pipe_top DUT (
    .clk(clk), .rst(rst), .imem_req_o(imem_req), .imem_addr_o(imem_addr),
    .imem_gnt_i(imem_gnt_i), .imem_rdata_i(imem_rdata_i), .psel_o(psel),
    .penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr), .pwdata_o(pwdata),
    .prdata_i(prdata_i), .pready_i(pready_i), .retire_valid_o(retire_valid),
    .retire_pc_o(retire_pc), .retire_kind_o(retire_kind), .retire_rd_o(retire_rd),
    .retire_data_o(retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // imem answers in the grant cycle, APB slave reads combinationally
  assign imem_rdata_i = prog[imem_addr[8:2]];
  assign prdata_i     = apb_mem[paddr[7:0]];

  always @(posedge clk) begin
    rnd = $random(seed);
    imem_gnt_i <= imem_req && (gnt_random ? rnd[0] : 1'b1);  // grant only behind a request
    pready_i   <= ready_random ? (rnd[2:1] != 2'b00) : 1'b1;
    if (psel && penable && pready_i && pwrite) begin
      apb_mem[paddr[7:0]] <= pwdata;
    end
  end

  always @(posedge clk) begin
    if (!rst && retire_valid) begin
      got_pc.push_back(retire_pc);
      got_kind.push_back(retire_kind);
      got_rd.push_back(retire_rd);
      got_data.push_back(retire_data);
    end
  end

  function automatic logic [7:0] fill_byte(logic [7:0] a);
    return {a[3:0], a[7:4]} ^ 8'h3c;
  endfunction

  function automatic logic [31:0] make_instr(instr_kind_e kind, logic [4:0] rd,
                                             logic [4:0] rs1, logic [7:0] a, logic [7:0] b);
    instr_t ins;
    ins.kind = kind;
    ins.rd   = rd;
    ins.rs1  = rs1;
    ins.op_a = a;
    ins.op_b = b;
    ins.pad  = 3'b000;
    return ins;
  endfunction

  task automatic place_instr(input int word, input logic [31:0] ins);
    prog[7'(word)] = ins;
  endtask

  task automatic check_retire(input string name, input int idx,
                              input logic [31:0] e_pc, input instr_kind_e e_kind,
                              input logic [4:0] e_rd, input logic [15:0] e_data,
                              input logic [31:0] a_pc, input instr_kind_e a_kind,
                              input logic [4:0] a_rd, input logic [15:0] a_data);
    checks++;
    if (e_pc !== a_pc || e_kind !== a_kind || e_rd !== a_rd || e_data !== a_data) begin
      errors++;
      $display("FAILED %s retire %0d: expected pc=%h %s rd=%0d data=%h, got pc=%h %s rd=%0d data=%h",
               name, idx, e_pc, e_kind.name(), e_rd, e_data,
               a_pc, a_kind.name(), a_rd, a_data);
    end
  endtask

  task automatic check_mem(input string name, input logic [7:0] addr,
                           input logic [7:0] e_byte, input logic [7:0] a_byte);
    checks++;
    if (e_byte !== a_byte) begin
      errors++;
      $display("FAILED %s mem[%h]: expected %h, got %h", name, addr, e_byte, a_byte);
    end
  endtask

  // walks the program the way the ISA rules say it executes
  task automatic build_expected(input int count);
    logic [31:0] pc;
    logic [31:0] next;
    instr_t      ins;
    logic [7:0]  addr;
    logic [15:0] data;
    bit          keep;
    int          steps;
    pc    = `PIPE_RESET_PC;
    steps = 0;
    while (exp_pc.size() < count && steps < 4096) begin
      ins  = instr_t'(prog[pc[8:2]]);
      next = pc + 32'd4;
      addr = ins.op_a + ins.op_b;
      keep = 1'b1;
      data = 16'h0000;
      case (ins.kind)
        KIND_ALU:   data = {8'h00, ins.op_a} + {8'h00, ins.op_b};
        KIND_MUL:   data = {8'h00, ins.op_a} * {8'h00, ins.op_b};
        KIND_LOAD:  data = {8'h00, model_mem[addr]};
        KIND_STORE: begin
          model_mem[addr] = ins.op_b;
          data = {ins.op_b, addr};  // store byte rides above the address
        end
        KIND_JUMP: begin
          data = next[15:0];
          next = {22'd0, ins.op_a, 2'b00};
        end
        KIND_ECALL: next = `PIPE_TRAP_VEC;
        default:    keep = 1'b0;  // nop never retires
      endcase
      if (keep) begin
        exp_pc.push_back(pc);
        exp_kind.push_back(ins.kind);
        exp_rd.push_back(ins.rd);
        exp_data.push_back(data);
      end
      pc = next;
      steps++;
    end
  endtask

  // raise reset and blank the program while the DUT is held
  task automatic hold_reset();
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < 128; i++) begin
      prog[i] = '0;
    end
  endtask

  task automatic run_program(input string name, input int count,
                             input logic rand_gnt, input logic rand_ready);
    int waited;
    gnt_random   = rand_gnt;
    ready_random = rand_ready;
    for (int i = 0; i < 256; i++) begin
      apb_mem[i]   = fill_byte(8'(i));
      model_mem[i] = fill_byte(8'(i));
    end
    exp_pc.delete();
    exp_kind.delete();
    exp_rd.delete();
    exp_data.delete();
    got_pc.delete();
    got_kind.delete();
    got_rd.delete();
    got_data.delete();
    build_expected(count);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    while (got_pc.size() < count && waited < 3000) begin
      @(posedge clk);
      waited++;
    end
    if (got_pc.size() < count || exp_pc.size() < count) begin
      errors++;
      $display("%s: timed out with %0d of %0d instructions retired",
               name, got_pc.size(), count);
    end else begin
      for (int i = 0; i < count; i++) begin
        check_retire(name, i, exp_pc[i], exp_kind[i], exp_rd[i], exp_data[i],
                     got_pc[i], got_kind[i], got_rd[i], got_data[i]);
      end
    end
  endtask

  task automatic alu_sequence_test();
    hold_reset();
    place_instr(0, make_instr(KIND_ALU, 5'd1, 5'd0, 8'd3, 8'd4));
    place_instr(1, make_instr(KIND_ALU, 5'd2, 5'd0, 8'd200, 8'd100));
    place_instr(2, make_instr(KIND_ALU, 5'd3, 5'd1, 8'd255, 8'd255));
    place_instr(3, make_instr(KIND_ALU, 5'd4, 5'd2, 8'd0, 8'd0));
    place_instr(4, make_instr(KIND_ALU, 5'd5, 5'd0, 8'd17, 8'd25));
    place_instr(5, make_instr(KIND_ALU, 5'd6, 5'd3, 8'd128, 8'd1));
    place_instr(6, make_instr(KIND_JUMP, 5'd0, 5'd0, 8'd6, 8'd0));  // park here
    run_program("alu_sequence", 8, 1'b0, 1'b0);
  endtask

  task automatic jump_test();
    hold_reset();
    place_instr(0, make_instr(KIND_ALU, 5'd1, 5'd0, 8'd9, 8'd1));
    place_instr(1, make_instr(KIND_JUMP, 5'd31, 5'd0, 8'd10, 8'd0));
    place_instr(2, make_instr(KIND_ALU, 5'd2, 5'd0, 8'd1, 8'd1));  // shadow, killed
    place_instr(3, make_instr(KIND_ALU, 5'd3, 5'd0, 8'd2, 8'd2));
    place_instr(10, make_instr(KIND_ALU, 5'd4, 5'd0, 8'd40, 8'd2));
    place_instr(11, make_instr(KIND_JUMP, 5'd0, 5'd0, 8'd11, 8'd0));
    run_program("jump", 5, 1'b0, 1'b0);
  endtask

  task automatic mul_test();
    hold_reset();
    place_instr(0, make_instr(KIND_MUL, 5'd1, 5'd0, 8'd13, 8'd11));
    place_instr(1, make_instr(KIND_MUL, 5'd2, 5'd0, 8'd255, 8'd255));
    place_instr(2, make_instr(KIND_ALU, 5'd3, 5'd2, 8'd5, 8'd6));
    place_instr(3, make_instr(KIND_ALU, 5'd4, 5'd0, 8'd7, 8'd8));
    place_instr(4, make_instr(KIND_JUMP, 5'd0, 5'd0, 8'd4, 8'd0));
    run_program("multiply", 6, 1'b0, 1'b0);
  endtask

  task automatic mem_test();
    hold_reset();
    place_instr(0, make_instr(KIND_STORE, 5'd0, 5'd0, 8'h10, 8'h33));  // 0x43 <- 0x33
    place_instr(1, make_instr(KIND_LOAD, 5'd5, 5'd0, 8'h40, 8'h03));
    place_instr(2, make_instr(KIND_ALU, 5'd6, 5'd5, 8'd1, 8'd2));      // load-use
    place_instr(3, make_instr(KIND_STORE, 5'd0, 5'd0, 8'h80, 8'h7e));  // 0xfe <- 0x7e
    place_instr(4, make_instr(KIND_LOAD, 5'd7, 5'd0, 8'hf0, 8'h0e));
    place_instr(5, make_instr(KIND_LOAD, 5'd8, 5'd0, 8'h10, 8'h02));   // untouched byte
    place_instr(6, make_instr(KIND_ALU, 5'd9, 5'd8, 8'd3, 8'd3));
    place_instr(7, make_instr(KIND_JUMP, 5'd0, 5'd0, 8'd7, 8'd0));
    run_program("load_store", 9, 1'b0, 1'b1);
    check_mem("load_store", 8'h43, model_mem[8'h43], apb_mem[8'h43]);
    check_mem("load_store", 8'hfe, model_mem[8'hfe], apb_mem[8'hfe]);
  endtask

  task automatic ecall_test();
    hold_reset();
    place_instr(0, make_instr(KIND_ALU, 5'd1, 5'd0, 8'd4, 8'd4));
    place_instr(1, make_instr(KIND_ECALL, 5'd0, 5'd0, 8'd0, 8'd0));
    place_instr(2, make_instr(KIND_ALU, 5'd2, 5'd0, 8'd1, 8'd1));  // younger, killed
    place_instr(3, make_instr(KIND_ALU, 5'd3, 5'd0, 8'd2, 8'd1));
    place_instr(`PIPE_TRAP_VEC >> 2, make_instr(KIND_ALU, 5'd4, 5'd0, 8'd50, 8'd5));
    place_instr((`PIPE_TRAP_VEC >> 2) + 1, make_instr(KIND_JUMP, 5'd0, 5'd0, 8'd65, 8'd0));
    run_program("ecall", 5, 1'b0, 1'b0);
  endtask

  task automatic random_grant_test();
    hold_reset();
    place_instr(0, make_instr(KIND_ALU, 5'd1, 5'd0, 8'd21, 8'd21));
    place_instr(1, make_instr(KIND_MUL, 5'd2, 5'd1, 8'd19, 8'd7));
    place_instr(2, make_instr(KIND_STORE, 5'd0, 5'd0, 8'h30, 8'h5a));  // 0x8a
    place_instr(3, make_instr(KIND_LOAD, 5'd9, 5'd0, 8'h80, 8'h0a));
    place_instr(4, make_instr(KIND_ALU, 5'd10, 5'd9, 8'd60, 8'd70));
    place_instr(5, make_instr(KIND_JUMP, 5'd1, 5'd0, 8'd20, 8'd0));
    place_instr(6, make_instr(KIND_ALU, 5'd11, 5'd0, 8'd1, 8'd1));
    place_instr(20, make_instr(KIND_ECALL, 5'd0, 5'd0, 8'd0, 8'd0));
    place_instr(21, make_instr(KIND_ALU, 5'd12, 5'd0, 8'd2, 8'd2));
    place_instr(64, make_instr(KIND_ALU, 5'd13, 5'd0, 8'd90, 8'd9));
    place_instr(65, make_instr(KIND_MUL, 5'd14, 5'd0, 8'd200, 8'd3));
    place_instr(66, make_instr(KIND_JUMP, 5'd0, 5'd0, 8'd66, 8'd0));
    run_program("random_grant", 11, 1'b1, 1'b1);
  endtask

  initial begin
    rst          = 1'b1;
    imem_gnt_i   = 1'b0;
    pready_i     = 1'b0;
    gnt_random   = 1'b0;
    ready_random = 1'b0;
    errors       = 0;
    checks       = 0;
    for (int i = 0; i < 128; i++) begin
      prog[i] = '0;
    end
    alu_sequence_test();
    jump_test();
    mul_test();
    mem_test();
    ecall_test();
    random_grant_test();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* pipe_hazard.f */
+incdir+.
pipe_pkg.sv
pipe_ctrl_if.sv
pipe_ctrl.sv
stage_reg.sv
fetch_unit.sv
exec_unit.sv
mem_apb.sv
retire_unit.sv
pipe_top.sv
pipe_asserts.sv
pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pipe_hazard testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module pipe_tb -f pipe_hazard.f -o Vpipe_tb \
  && ./obj_dir/Vpipe_tb 2>&1 | tee sim.log \
  || echo "build or simulation failed" > sim.log
grep -q -e "ERRORS FOUND" -e "%Error" -e "simulation failed" sim.log && echo "FAIL" && exit 1
grep -q "NO ERRORS" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1
